// File: src/eth_rx_config.svh
`ifndef ETH_RX_CONFIG_SVH
`define ETH_RX_CONFIG_SVH

// Payload buffer size in bytes, power of two
`define ETH_RX_BUF_DEPTH 2048

// Output credits held after reset
`define ETH_RX_CREDITS 4

// Field lengths in bytes
`define ETH_RX_PREAMBLE_BYTES 7
`define ETH_RX_HEADER_BYTES   14
`define ETH_RX_FCS_BYTES      4

`define ETH_RX_PREAMBLE_VAL 8'h55
`define ETH_RX_SFD_VAL      8'hD5

`endif

// File: src/eth_rx_pkg.sv
`default_nettype none
`include "eth_rx_config.svh"

package eth_rx_pkg;

    localparam int BUF_AW = $clog2(`ETH_RX_BUF_DEPTH);

    typedef logic [7:0]      byte_t;
    typedef logic [47:0]     mac_addr_t;   // First wire byte in 47:40
    typedef logic [31:0]     crc_t;
    typedef logic [10:0]     frame_len_t;
    typedef logic [BUF_AW:0] buf_ptr_t;    // Top bit is the wrap bit

    // Tag carried with each byte between stages
    typedef enum logic [1:0] {
        FLD_HEADER,
        FLD_PAYLOAD,
        FLD_FCS
    } rx_field_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_SFD,
        ST_HEADER,
        ST_PAYLOAD,
        ST_FCS
    } parser_state_t;

endpackage

`default_nettype wire

// File: src/rx_byte_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rx_byte_if
    import eth_rx_pkg::*;
();

    byte_t     data;
    logic      valid;
    rx_field_t field;
    logic      frame_end;  // Cycle after last FCS byte, or abort
    logic      accept;     // Only with frame_end
    logic      abort;

    modport src (
        output data, valid, field, frame_end, accept, abort
    );

    modport dst (
        input data, valid, field, frame_end, accept, abort
    );

endinterface

`default_nettype wire

// File: src/frame_parser.sv
`timescale 1ns/1ps
`default_nettype none
`include "eth_rx_config.svh"

module frame_parser
    import eth_rx_pkg::*;
(
    input wire            clk_i,
    input wire            rst_i,

    input wire byte_t     rx_d_i,
    input wire            rx_dv_i,

    input wire            check_destination_i,
    input wire mac_addr_t station_mac_i,
    input wire frame_len_t payload_len_i,

    rx_byte_if.src        byte_o
);

    localparam int         HDR_BITS = `ETH_RX_HEADER_BYTES * $bits(byte_t);
    localparam frame_len_t PRE_LAST = frame_len_t'(`ETH_RX_PREAMBLE_BYTES - 2); // First one in idle
    localparam frame_len_t HDR_LAST = frame_len_t'(`ETH_RX_HEADER_BYTES - 1);
    localparam frame_len_t FCS_LAST = frame_len_t'(`ETH_RX_FCS_BYTES - 1);

    byte_t               rxd_q;
    logic                rxdv_q;
    logic                rxdv_prev_q;
    logic                start;
    parser_state_t       state_q;
    parser_state_t       state_d;
    frame_len_t          cnt_q;
    logic                abort;
    logic                end_pend_q;
    logic [HDR_BITS-1:0] hdr_q;
    mac_addr_t           dst_mac;
    rx_field_t           fld;

    assign start   = rxdv_q && !rxdv_prev_q;
    assign dst_mac = hdr_q[HDR_BITS-1 -: $bits(mac_addr_t)];

    always_ff @(posedge clk_i) begin
        rxd_q <= rx_d_i;
        if (rst_i) begin
            rxdv_q      <= 1'b0;
            rxdv_prev_q <= 1'b0;
        end else begin
            rxdv_q      <= rx_dv_i;
            rxdv_prev_q <= rxdv_q;
        end
    end

    always_comb begin
        state_d = state_q;
        abort   = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (start && rxd_q == `ETH_RX_PREAMBLE_VAL) begin
                    state_d = ST_PREAMBLE;
                end
            end
            ST_PREAMBLE: begin
                if (!rxdv_q || rxd_q != `ETH_RX_PREAMBLE_VAL) begin
                    abort = 1'b1;
                end else if (cnt_q == PRE_LAST) begin
                    state_d = ST_SFD;
                end
            end
            ST_SFD: begin
                if (!rxdv_q || rxd_q != `ETH_RX_SFD_VAL) begin
                    abort = 1'b1;
                end else begin
                    state_d = ST_HEADER;
                end
            end
            ST_HEADER: begin
                if (!rxdv_q) begin
                    abort = 1'b1;
                end else if (cnt_q == HDR_LAST) begin
                    state_d = ST_PAYLOAD;
                end
            end
            ST_PAYLOAD: begin
                if (!rxdv_q) begin
                    abort = 1'b1;
                end else if (cnt_q == frame_len_t'(payload_len_i - 1'b1)) begin
                    state_d = ST_FCS;
                end
            end
            ST_FCS: begin
                if (!rxdv_q) begin
                    abort = 1'b1;
                end else if (cnt_q == FCS_LAST) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
        if (abort) begin
            state_d = ST_IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_d != state_q || state_q == ST_IDLE) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_comb begin
        case (state_q)
            ST_HEADER:  fld = FLD_HEADER;
            ST_PAYLOAD: fld = FLD_PAYLOAD;
            default:    fld = FLD_FCS;    // Also the abort tag
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            byte_o.valid     <= 1'b0;
            byte_o.frame_end <= 1'b0;
            byte_o.abort     <= 1'b0;
            end_pend_q       <= 1'b0;
        end else begin
            byte_o.valid     <= !abort && (state_q inside {ST_HEADER, ST_PAYLOAD, ST_FCS});
            end_pend_q       <= (state_q == ST_FCS) && (state_d == ST_IDLE) && !abort;
            byte_o.frame_end <= end_pend_q || abort;
            byte_o.abort     <= abort;
        end
    end

    always_ff @(posedge clk_i) begin
        byte_o.data   <= rxd_q;
        byte_o.field  <= abort ? FLD_FCS : fld;
        byte_o.accept <= !check_destination_i || (dst_mac == station_mac_i);
        if (state_q == ST_HEADER) begin
            hdr_q <= {hdr_q[HDR_BITS-$bits(byte_t)-1:0], rxd_q};
        end
    end

    // Once idle, only the last FCS byte is left and frame_end follows
    assert property (@(posedge clk_i) disable iff (rst_i)
        (byte_o.valid && state_q == ST_IDLE) |=> (byte_o.frame_end && !byte_o.valid));

endmodule

`default_nettype wire

// File: src/fcs_check.sv
`timescale 1ns/1ps
`default_nettype none
`include "eth_rx_config.svh"

module fcs_check
    import eth_rx_pkg::*;
(
    input wire     clk_i,
    input wire     rst_i,

    rx_byte_if.dst byte_i,
    rx_byte_if.src byte_o,

    output logic   crc_err_o,
    output logic   addr_miss_o
);

    localparam crc_t CRC_POLY = 32'hEDB88320;  // 0x04C11DB7 reflected
    localparam crc_t CRC_INIT = '1;

    crc_t crc_q;
    crc_t fcs_q;
    logic crc_en;
    logic fcs_en;
    logic crc_match;

    // One octet, LSB first
    function automatic crc_t crc_byte(crc_t crc, byte_t data);
        crc_t c;
        c = crc ^ crc_t'(data);
        for (int i = 0; i < $bits(byte_t); i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    assign crc_en    = byte_i.valid && (byte_i.field != FLD_FCS);
    assign fcs_en    = byte_i.valid && (byte_i.field == FLD_FCS);
    assign crc_match = (fcs_q == ~crc_q);

    always_ff @(posedge clk_i) begin
        if (rst_i || byte_i.frame_end) begin
            crc_q <= CRC_INIT;
        end else if (crc_en) begin
            crc_q <= crc_byte(crc_q, byte_i.data);
        end
    end

    // FCS arrives low byte first
    always_ff @(posedge clk_i) begin
        if (fcs_en) begin
            fcs_q <= {byte_i.data, fcs_q[31:8]};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            byte_o.valid     <= 1'b0;
            byte_o.frame_end <= 1'b0;
            byte_o.abort     <= 1'b0;
            crc_err_o        <= 1'b0;
            addr_miss_o      <= 1'b0;
        end else begin
            byte_o.valid     <= byte_i.valid && (byte_i.field == FLD_PAYLOAD);
            byte_o.frame_end <= byte_i.frame_end;
            byte_o.abort     <= byte_i.abort;
            crc_err_o        <= byte_i.frame_end && !byte_i.abort && !crc_match;
            addr_miss_o      <= byte_i.frame_end && !byte_i.abort && !byte_i.accept;
        end
    end

    always_ff @(posedge clk_i) begin
        byte_o.data   <= byte_i.data;
        byte_o.field  <= byte_i.field;
        byte_o.accept <= byte_i.accept && crc_match && !byte_i.abort;
    end

    // Parser closes the frame right after the last FCS byte
    assert property (@(posedge clk_i) disable iff (rst_i)
        fcs_en [*`ETH_RX_FCS_BYTES] |=> (byte_i.frame_end && !fcs_en));

endmodule

`default_nettype wire

// File: src/payload_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "eth_rx_config.svh"

module payload_buffer
    import eth_rx_pkg::*;
(
    input wire     clk_i,
    input wire     rst_i,

    rx_byte_if.dst byte_i,
    input wire     crc_err_i,
    input wire     addr_miss_i,

    input wire     out_credit_i,
    output logic   out_valid_o,
    output byte_t  out_data_o,
    output logic   out_last_o,

    output logic   frame_valid_o,
    output logic   crc_err_o,
    output logic   addr_miss_o,
    output logic   overflow_o
);

    localparam buf_ptr_t DEPTH = buf_ptr_t'(`ETH_RX_BUF_DEPTH);
    localparam int       CW    = $clog2(`ETH_RX_CREDITS + 1);

    byte_t    mem      [`ETH_RX_BUF_DEPTH];
    logic     last_mem [`ETH_RX_BUF_DEPTH];

    buf_ptr_t wr_spec_q;   // Speculative, current frame
    buf_ptr_t wr_cmt_q;    // Visible to the read side
    buf_ptr_t rd_q;
    buf_ptr_t last_ptr;
    logic     full;
    logic     wr_en;
    logic     ovf_q;
    logic     commit;
    logic     send;
    logic [CW-1:0] credit_q;

    assign full     = (buf_ptr_t'(wr_spec_q - rd_q) == DEPTH);
    assign wr_en    = byte_i.valid && !full;
    assign commit   = byte_i.frame_end && byte_i.accept && !ovf_q;
    assign last_ptr = commit ? buf_ptr_t'(wr_spec_q - 1'b1) : wr_spec_q;

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_spec_q[BUF_AW-1:0]] <= byte_i.data;
        end
        if (wr_en || commit) begin
            last_mem[last_ptr[BUF_AW-1:0]] <= commit;  // Mark frame end on commit
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_spec_q <= '0;
            wr_cmt_q  <= '0;
            ovf_q     <= 1'b0;
        end else if (byte_i.frame_end) begin
            ovf_q <= 1'b0;
            if (commit) begin
                wr_cmt_q <= wr_spec_q;
            end else begin
                wr_spec_q <= wr_cmt_q;  // Roll back
            end
        end else if (byte_i.valid) begin
            if (full) begin
                ovf_q <= 1'b1;
            end else begin
                wr_spec_q <= wr_spec_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            frame_valid_o <= 1'b0;
            crc_err_o     <= 1'b0;
            addr_miss_o   <= 1'b0;
            overflow_o    <= 1'b0;
        end else begin
            frame_valid_o <= byte_i.frame_end && !byte_i.abort;  // Aborts stay silent
            crc_err_o     <= crc_err_i;
            addr_miss_o   <= addr_miss_i;
            overflow_o    <= ovf_q;
        end
    end

    assign send        = (rd_q != wr_cmt_q) && (credit_q != '0);
    assign out_valid_o = send;
    assign out_data_o  = mem[rd_q[BUF_AW-1:0]];
    assign out_last_o  = send && last_mem[rd_q[BUF_AW-1:0]];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_q     <= '0;
            credit_q <= CW'(`ETH_RX_CREDITS);
        end else begin
            if (send) begin
                rd_q <= rd_q + 1'b1;
            end
            credit_q <= credit_q - CW'(send) + CW'(out_credit_i);
        end
    end

    assert property (@(posedge clk_i) disable iff (rst_i)
        buf_ptr_t'(wr_cmt_q - rd_q) <= DEPTH);

    // Consumer never returns more than it was given
    assert property (@(posedge clk_i) disable iff (rst_i)
        credit_q <= CW'(`ETH_RX_CREDITS));

endmodule

`default_nettype wire

// File: src/eth_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module eth_rx_top
    import eth_rx_pkg::*;
(
    input wire             clk_i,
    input wire             rst_i,

    input wire byte_t      rx_d_i,
    input wire             rx_dv_i,

    input wire             check_destination_i,
    input wire mac_addr_t  station_mac_i,
    input wire frame_len_t payload_len_i,

    input wire             out_credit_i,
    output logic           out_valid_o,
    output byte_t          out_data_o,
    output logic           out_last_o,

    output logic           frame_valid_o,
    output logic           crc_err_o,
    output logic           addr_miss_o,
    output logic           overflow_o
);

    logic crc_err;
    logic addr_miss;

    rx_byte_if parsed_if ();
    rx_byte_if checked_if ();

    frame_parser i_frame_parser (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .rx_d_i             (rx_d_i),
        .rx_dv_i            (rx_dv_i),
        .check_destination_i(check_destination_i),
        .station_mac_i      (station_mac_i),
        .payload_len_i      (payload_len_i),
        .byte_o             (parsed_if)
    );

    fcs_check i_fcs_check (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .byte_i     (parsed_if),
        .byte_o     (checked_if),
        .crc_err_o  (crc_err),
        .addr_miss_o(addr_miss)
    );

    payload_buffer i_payload_buffer (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .byte_i       (checked_if),
        .crc_err_i    (crc_err),
        .addr_miss_i  (addr_miss),
        .out_credit_i (out_credit_i),
        .out_valid_o  (out_valid_o),
        .out_data_o   (out_data_o),
        .out_last_o   (out_last_o),
        .frame_valid_o(frame_valid_o),
        .crc_err_o    (crc_err_o),
        .addr_miss_o  (addr_miss_o),
        .overflow_o   (overflow_o)
    );

endmodule

`default_nettype wire

// File: verification/eth_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "eth_rx_config.svh"

module eth_rx_tb
    import eth_rx_pkg::*;
();

    localparam int         NUM_ROWS     = 15;
    localparam int         GAP_CYCLES   = 12;
    localparam int         CREDIT_DELAY = 3;    // Slot freed a few cycles after each byte
    localparam int         PRE_SFD      = `ETH_RX_PREAMBLE_BYTES + 1;
    localparam mac_addr_t  STATION      = 48'h02_00_5E_10_20_30;
    localparam mac_addr_t  OTHER_MAC    = 48'h02_00_5E_10_20_31;
    localparam mac_addr_t  SRC_MAC      = 48'h02_AA_BB_CC_DD_EE;
    localparam logic [1:0] CUT_NONE     = 2'd0;
    localparam logic [1:0] CUT_PAYLOAD  = 2'd1; // rx_dv_i drops mid payload
    localparam logic [1:0] CUT_SFD      = 2'd2;

    typedef struct packed {
        frame_len_t len;
        mac_addr_t  dst;
        logic       chk;
        logic       bad_fcs;
        logic [1:0] cut;
        logic       hold;
        logic       crc;
        logic       addr;
        logic       ovf;
        logic       dlv;
    } frame_row_t;

    logic       clk_i = 1'b0;
    logic       rst_i;
    byte_t      rx_d_i;
    logic       rx_dv_i;
    logic       check_destination_i;
    frame_len_t payload_len_i;
    logic       out_credit_i = 1'b0;
    logic       out_valid_o;
    byte_t      out_data_o;
    logic       out_last_o;
    logic       frame_valid_o;
    logic       crc_err_o;
    logic       addr_miss_o;
    logic       overflow_o;

    frame_row_t rows [NUM_ROWS];
    logic       table_loaded = 1'b0;
    logic       hold_credits = 1'b0;
    int         cycle = 0;
    int         credits_left = `ETH_RX_CREDITS;
    int         committed_bytes = 0;
    int         received_bytes = 0;
    byte_t      wire_q [$];
    byte_t      exp_bytes [$];
    logic       exp_last [$];
    int         release_q [$];
    int         stat_cycle_q [$];
    logic [2:0] stat_flags_q [$];  // crc, addr, ovf

    eth_rx_top dut0 (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .rx_d_i             (rx_d_i),
        .rx_dv_i            (rx_dv_i),
        .check_destination_i(check_destination_i),
        .station_mac_i      (STATION),
        .payload_len_i      (payload_len_i),
        .out_credit_i       (out_credit_i),
        .out_valid_o        (out_valid_o),
        .out_data_o         (out_data_o),
        .out_last_o         (out_last_o),
        .frame_valid_o      (frame_valid_o),
        .crc_err_o          (crc_err_o),
        .addr_miss_o        (addr_miss_o),
        .overflow_o         (overflow_o)
    );

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t got);
        if (got !== exp) begin
            stop_with_error($sformatf("Mismatch %s exp %h got %h", name, exp, got));
        end
    endtask

    task automatic check_last(input logic exp, input logic got);
        if (got !== exp) begin
            stop_with_error($sformatf("Mismatch out_last_o exp %h got %h", exp, got));
        end
    endtask

    task automatic check_status(input logic exp_crc, input logic exp_addr, input logic exp_ovf,
                                input logic got_crc, input logic got_addr, input logic got_ovf);
        if (got_crc !== exp_crc) begin
            stop_with_error($sformatf("Mismatch crc_err_o exp %h got %h", exp_crc, got_crc));
        end
        if (got_addr !== exp_addr) begin
            stop_with_error($sformatf("Mismatch addr_miss_o exp %h got %h", exp_addr, got_addr));
        end
        if (got_ovf !== exp_ovf) begin
            stop_with_error($sformatf("Mismatch overflow_o exp %h got %h", exp_ovf, got_ovf));
        end
    endtask

    // Bit-serial CRC-32, LSB of each octet first
    function automatic crc_t crc_step(input crc_t c, input byte_t b);
        logic fb;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ b[i];
            c  = c >> 1;
            if (fb) begin
                c = c ^ 32'hEDB88320;
            end
        end
        return c;
    endfunction

    function automatic frame_row_t make_row(input int len, input mac_addr_t dst,
                                            input logic chk, input logic bad_fcs,
                                            input logic [1:0] cut, input logic hold,
                                            input logic crc, input logic addr,
                                            input logic ovf, input logic dlv);
        frame_row_t r;
        r.len     = frame_len_t'(len);
        r.dst     = dst;
        r.chk     = chk;
        r.bad_fcs = bad_fcs;
        r.cut     = cut;
        r.hold    = hold;
        r.crc     = crc;
        r.addr    = addr;
        r.ovf     = ovf;
        r.dlv     = dlv;
        return r;
    endfunction

    // len, dst, chk, bad_fcs, cut, hold | crc, addr, ovf, delivered
    task automatic load_table();
        rows[0]  = make_row(64,  STATION,   0, 0, CUT_NONE,    0, 0, 0, 0, 1);
        rows[1]  = make_row(46,  OTHER_MAC, 0, 0, CUT_NONE,    0, 0, 0, 0, 1); // Filter off
        rows[2]  = make_row(60,  STATION,   0, 1, CUT_NONE,    0, 1, 0, 0, 0);
        rows[3]  = make_row(50,  OTHER_MAC, 1, 0, CUT_NONE,    0, 0, 1, 0, 0);
        rows[4]  = make_row(72,  STATION,   1, 0, CUT_NONE,    0, 0, 0, 0, 1);
        rows[5]  = make_row(1,   OTHER_MAC, 0, 0, CUT_NONE,    0, 0, 0, 0, 1);
        rows[6]  = make_row(700, STATION,   0, 0, CUT_NONE,    1, 0, 0, 0, 1);
        rows[7]  = make_row(700, STATION,   0, 0, CUT_NONE,    1, 0, 0, 0, 1);
        rows[8]  = make_row(700, STATION,   0, 0, CUT_NONE,    1, 0, 0, 1, 0); // Buffer full
        rows[9]  = make_row(600, STATION,   0, 0, CUT_NONE,    1, 0, 0, 0, 1);
        rows[10] = make_row(80,  STATION,   0, 0, CUT_NONE,    0, 0, 0, 0, 1);
        rows[11] = make_row(40,  STATION,   0, 0, CUT_PAYLOAD, 0, 0, 0, 0, 0);
        rows[12] = make_row(30,  STATION,   0, 0, CUT_NONE,    0, 0, 0, 0, 1);
        rows[13] = make_row(40,  STATION,   0, 0, CUT_SFD,     0, 0, 0, 0, 0);
        rows[14] = make_row(20,  STATION,   1, 0, CUT_NONE,    0, 0, 0, 0, 1);
    endtask

    task automatic build_frame(input frame_row_t r);
        byte_t body [$];
        byte_t b;
        crc_t  crc;
        wire_q.delete();
        for (int i = 0; i < 6; i++) begin
            body.push_back(r.dst[47 - 8*i -: 8]);
        end
        for (int i = 0; i < 6; i++) begin
            body.push_back(SRC_MAC[47 - 8*i -: 8]);
        end
        body.push_back(8'h88);
        body.push_back(8'hB5);
        for (int i = 0; i < int'(r.len); i++) begin
            b = byte_t'($urandom);
            body.push_back(b);
            if (r.dlv) begin
                exp_bytes.push_back(b);
                exp_last.push_back(i == int'(r.len) - 1);
            end
        end
        if (r.dlv) begin
            committed_bytes += int'(r.len);
        end
        for (int i = 0; i < `ETH_RX_PREAMBLE_BYTES; i++) begin
            wire_q.push_back(`ETH_RX_PREAMBLE_VAL);
        end
        wire_q.push_back(r.cut == CUT_SFD ? (`ETH_RX_SFD_VAL ^ 8'h01) : `ETH_RX_SFD_VAL);
        crc = '1;
        foreach (body[i]) begin
            crc = crc_step(crc, body[i]);
            wire_q.push_back(body[i]);
        end
        crc = ~crc;
        if (r.bad_fcs) begin
            crc[13] = ~crc[13];
        end
        for (int i = 0; i < `ETH_RX_FCS_BYTES; i++) begin
            wire_q.push_back(crc[8*i +: 8]);  // Low byte first
        end
    endtask

    task automatic send_frame(input frame_row_t r);
        int stop_at;
        stop_at = wire_q.size();
        if (r.cut == CUT_PAYLOAD) begin
            stop_at = PRE_SFD + `ETH_RX_HEADER_BYTES + int'(r.len) / 2;
        end
        for (int i = 0; i < stop_at; i++) begin
            @(negedge clk_i);
            if (i == 0) begin
                payload_len_i       <= r.len;
                check_destination_i <= r.chk;
            end
            rx_dv_i <= 1'b1;
            rx_d_i  <= wire_q[i];
        end
        // Status lands 4 edges after the edge that samples the last FCS byte
        if (r.cut == CUT_NONE) begin
            stat_cycle_q.push_back(cycle + 5);
            stat_flags_q.push_back({r.crc, r.addr, r.ovf});
        end
        @(negedge clk_i);
        rx_dv_i <= 1'b0;
        rx_d_i  <= '0;
        repeat (GAP_CYCLES) @(negedge clk_i);
    endtask

    task automatic wait_for_drain();
        while (exp_bytes.size() != 0 || stat_cycle_q.size() != 0) begin
            @(negedge clk_i);
        end
    endtask

    // Output consumer, credit model and payload check
    always @(negedge clk_i) begin : collect
        logic pulse;
        pulse = 1'b0;
        if (out_valid_o === 1'b1) begin
            if (credits_left == 0) begin
                stop_with_error("out_valid_o was asserted with no credit outstanding");
            end
            if (exp_bytes.size() == 0) begin
                stop_with_error("Output byte appeared with no accepted frame pending");
            end
            check_byte("out_data_o", exp_bytes.pop_front(), out_data_o);
            check_last(exp_last.pop_front(), out_last_o);
            received_bytes++;
            credits_left--;
            release_q.push_back(cycle + CREDIT_DELAY);
        end
        if (!hold_credits && release_q.size() != 0 && release_q[0] <= cycle) begin
            void'(release_q.pop_front());
            pulse = 1'b1;
            credits_left++;
        end
        out_credit_i <= pulse;
    end

    always @(negedge clk_i) begin
        if (frame_valid_o === 1'b1) begin
            if (stat_cycle_q.size() == 0) begin
                stop_with_error("frame_valid_o pulsed with no frame status expected");
            end
            if (cycle != stat_cycle_q[0]) begin
                stop_with_error($sformatf("frame_valid_o came at cycle %0d, expected cycle %0d",
                                          cycle, stat_cycle_q[0]));
            end
            check_status(stat_flags_q[0][2], stat_flags_q[0][1], stat_flags_q[0][0],
                         crc_err_o, addr_miss_o, overflow_o);
            void'(stat_cycle_q.pop_front());
            void'(stat_flags_q.pop_front());
        end else if (stat_cycle_q.size() != 0 && cycle > stat_cycle_q[0]) begin
            stop_with_error("frame_valid_o did not arrive for a completed frame");
        end
    end

    initial begin
        longint limit_cycles;
        limit_cycles = 200;
        wait (table_loaded);
        for (int i = 0; i < NUM_ROWS; i++) begin
            // Wire time with gap, plus as much again for draining the payload
            limit_cycles += PRE_SFD + `ETH_RX_HEADER_BYTES + `ETH_RX_FCS_BYTES + GAP_CYCLES
                            + 2 * int'(rows[i].len);
        end
        #(limit_cycles * 40);
        stop_with_error("Timeout, frames did not finish within the cycle budget");
    end

    initial begin
        int free_bytes;
        rst_i               = 1'b1;
        rx_d_i              = '0;
        rx_dv_i             = 1'b0;
        check_destination_i = 1'b0;
        payload_len_i       = '0;
        void'($urandom(32'hc950));
        load_table();
        table_loaded = 1'b1;
        repeat (2) @(negedge clk_i);
        rst_i <= 1'b0;
        repeat (4) @(negedge clk_i);
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].hold) begin
                hold_credits = 1'b1;
            end else if (hold_credits) begin
                hold_credits = 1'b0;
                wait_for_drain();
            end
            free_bytes = `ETH_RX_BUF_DEPTH - (committed_bytes - received_bytes);
            if (rows[i].cut == CUT_NONE && ((int'(rows[i].len) > free_bytes) != rows[i].ovf)) begin
                stop_with_error($sformatf("Row %0d overflow flag does not fit %0d free bytes",
                                          i, free_bytes));
            end
            build_frame(rows[i]);
            send_frame(rows[i]);
        end
        wait_for_drain();
        repeat (20) @(negedge clk_i);  // Catch stray output
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+src
src/eth_rx_pkg.sv
src/rx_byte_if.sv
src/frame_parser.sv
src/fcs_check.sv
src/payload_buffer.sv
src/eth_rx_top.sv
verification/eth_rx_tb.sv
